// ==== project.f ====
+incdir+test
common/cache_pkg.sv
design/sdram_cache/ahb_port.sv
design/sdram_cache/sdram_cache.sv
design/dram_sequencer.sv
design/cache_subsystem.sv
test/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SDRAM cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^TEST RESULT: PASS$'; then
    exit 0
fi
exit 1

// ==== test/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        error_count++;
        $display("error at %0t ns: %s (got %h, expected %h)", $time, what, got, exp);
    end
endtask

// Polls one cycle at a time, 1 ns after the edge
task automatic wait_ready(input int port, output bit ok);
    int cycles;
    cycles = 0;
    ok     = 1'b1;
    while (!hready[port] && ok) begin
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: port %0d kept hready low for %0d cycles", port, cycles);
            timeout_count++;
            ok = 1'b0;
        end else begin
            @(posedge CLK);
            #1;
            cycles++;
        end
    end
endtask

// Single word transfer, write data held through the data phase
task automatic ahb_transfer(input int port, input addr_t addr, input logic write,
                            input data_t wdata, output data_t rdata);
    bit ok;
    rdata = '0;
    wait_ready(port, ok);
    if (ok) begin
        haddr[port]  = addr;
        htrans[port] = NONSEQ;
        hwrite[port] = write;
        @(posedge CLK);
        #1;
        htrans[port] = IDLE;
        hwdata[port] = wdata;
        wait_ready(port, ok);
        rdata = hrdata[port];
    end
endtask

task automatic ahb_write(input int port, input addr_t addr, input data_t wdata);
    data_t echo;
    ahb_transfer(port, addr, 1'b1, wdata, echo);
    shadow[addr] = wdata;
endtask

task automatic ahb_read(input int port, input addr_t addr, output data_t rdata);
    ahb_transfer(port, addr, 1'b0, '0, rdata);
endtask

// Low beat at the lower byte address
function automatic data_t pattern_word(input addr_t addr);
    int b;
    b = int'(addr) >> 1;
    return {pattern_beat(b + 1), pattern_beat(b)};
endfunction

function automatic data_t expected_word(input addr_t addr);
    if (shadow.exists(addr)) begin
        return shadow[addr];
    end
    return pattern_word(addr);
endfunction

task automatic read_and_compare(input int port, input addr_t addr, input string what);
    data_t got;
    ahb_read(port, addr, got);
    check_equal(got, expected_word(addr), $sformatf("%s, port %0d, address %h", what, port, addr));
endtask

task automatic after_reset_state;
    check_equal(32'(hready), 32'hf, "hready after reset");
    check_equal(32'(hresp), 32'h0, "hresp after reset");
    check_equal(32'(dram_req), 32'h0, "dram_req after reset");
endtask

task automatic read_miss_then_hit;
    int bursts_before;
    read_and_compare(0, 16'h0100, "read miss");
    bursts_before = burst_count;
    read_and_compare(0, 16'h0100, "read hit");
    check_equal(32'(burst_count - bursts_before), 32'h0, "no SDRAM burst on a read hit");
endtask

task automatic write_then_evict;
    addr_t addr;
    data_t wval;
    data_t got;
    int    wb_before;
    int    bursts_before;
    int    base;
    int    word;
    beat_t exp_beat;
    addr = 16'h0224;
    wval = 32'h1234_abcd;
    ahb_write(1, addr, wval);
    ahb_read(1, addr, got);
    check_equal(got, wval, "read back after write");
    wb_before     = wb_count;
    bursts_before = burst_count;
    // Same index, other tag
    read_and_compare(2, 16'h0a24, "read of conflicting tag");
    check_equal(32'(wb_count - wb_before), 32'd1, "one writeback burst");
    check_equal(32'(burst_count - bursts_before), 32'd2, "writeback then fill");
    check_equal(32'(last_wb_line), 32'(addr >> OFS_BITS), "writeback line address");
    base = (int'(addr) >> OFS_BITS) * BURST;
    word = (int'(addr) >> 2) & 3;
    for (int k = 0; k < BURST; k++) begin
        if (k == 2 * word) begin
            exp_beat = wval[15:0];
        end else if (k == 2 * word + 1) begin
            exp_beat = wval[31:16];
        end else begin
            exp_beat = pattern_beat(base + k);
        end
        check_equal(32'(last_wb_beats[k]), 32'(exp_beat), $sformatf("writeback beat %0d", k));
    end
endtask

task automatic concurrent_ports;
    data_t got;
    fork
        read_and_compare(0, 16'h0340, "concurrent read");
        read_and_compare(3, 16'h0450, "concurrent read");
        ahb_write(1, 16'h0368, 32'hcafe_0104);
        ahb_read(2, 16'h0368, got);
    join
    // Port 1 is served first on the shared line, so port 2 sees its write
    check_equal(got, expected_word(16'h0368), "port 2 read of shared line");
endtask

task automatic random_traffic;
    int    port;
    addr_t addr;
    data_t wval;
    gaps_on = 1'b1;
    for (int n = 0; n < RANDOM_OPS; n++) begin
        port = int'($urandom % N_SRC);
        // Four tags over all indexes and words
        addr = addr_t'($urandom & 32'h1fc);
        if ($urandom % 2 == 1) begin
            wval = $urandom;
            ahb_write(port, addr, wval);
        end else begin
            read_and_compare(port, addr, "random read");
        end
    end
endtask

task automatic flush_and_compare;
    addr_t addr;
    int    b;
    for (int i = 0; i < N_LINES; i++) begin
        addr = EVICT_BASE + addr_t'(i * LINE_BYTES);
        read_and_compare(0, addr, "eviction read");
    end
    foreach (shadow[a]) begin
        b = int'(a) >> 1;
        check_equal({mem[b + 1], mem[b]}, shadow[a], $sformatf("SDRAM word at %h", a));
    end
endtask

`endif

// ==== test/tb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_top
    import cache_pkg::*;
();

    localparam int          RESET_CYCLES   = 10;
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          RANDOM_OPS     = 200;
    localparam int          SEED           = 32'hff15_da23;
    localparam logic [15:0] MEM_PATTERN    = 16'h5a5a;
    localparam int          MEM_BEATS      = MAX_BYTES / 2;
    localparam addr_t       EVICT_BASE     = 16'hf000;

    logic CLK = 1'b0;
    logic RESET_IN;

    addr_t      [N_SRC-1:0] haddr;
    trans_t     [N_SRC-1:0] htrans;
    size_t      [N_SRC-1:0] hsize;
    logic       [N_SRC-1:0] hwrite;
    data_t      [N_SRC-1:0] hwdata;
    data_t      [N_SRC-1:0] hrdata;
    logic       [N_SRC-1:0] hready;
    resp_t      [N_SRC-1:0] hresp;

    logic       dram_req;
    logic       dram_write;
    line_addr_t dram_addr;
    beat_t      dram_wdata;
    logic       dram_ack;
    beat_t      dram_rdata;

    // SDRAM model state
    beat_t      mem [0:MEM_BEATS-1];
    logic       gaps_on;
    int         burst_count;
    int         wb_count;
    line_addr_t last_wb_line;
    beat_t      last_wb_beats [0:BURST-1];

    // Expected AHB view of memory, written words only
    data_t      shadow [addr_t];
    int         error_count;
    int         timeout_count;

    always #5 CLK = ~CLK;

    cache_subsystem dut (
        .CLK        (CLK),
        .RESET_IN   (RESET_IN),
        .haddr      (haddr),
        .htrans     (htrans),
        .hsize      (hsize),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hrdata     (hrdata),
        .hready     (hready),
        .hresp      (hresp),
        .dram_req   (dram_req),
        .dram_write (dram_write),
        .dram_addr  (dram_addr),
        .dram_wdata (dram_wdata),
        .dram_ack   (dram_ack),
        .dram_rdata (dram_rdata)
    );

    // Initial SDRAM content of one beat address
    function automatic beat_t pattern_beat(input int beat_addr);
        return beat_t'(beat_addr) ^ MEM_PATTERN;
    endfunction

    // One 8-beat burst, ack gaps of up to two cycles when enabled
    task automatic serve_burst;
        int gap;
        int base;
        base = int'(dram_addr) * BURST;
        burst_count++;
        if (dram_write) begin
            wb_count++;
            last_wb_line = dram_addr;
        end
        for (int k = 0; k < BURST; k++) begin
            gap = gaps_on ? int'($urandom % 3) : 0;
            dram_ack = 1'b0;
            repeat (gap) begin
                @(posedge CLK);
                #1;
            end
            dram_ack   = 1'b1;
            dram_rdata = mem[base + k];
            #1;
            if (dram_write) begin
                mem[base + k]    = dram_wdata;
                last_wb_beats[k] = dram_wdata;
            end
            @(posedge CLK);
            #1;
        end
        dram_ack = 1'b0;
    endtask

    initial begin
        dram_ack   = 1'b0;
        dram_rdata = '0;
        forever begin
            @(posedge CLK);
            #1;
            if (dram_req && !RESET_IN) begin
                serve_burst();
            end
        end
    end

    `include "tb_tasks.svh"

    initial begin
        void'($urandom(SEED));
        RESET_IN      = 1'b1;
        haddr         = '0;
        hwrite        = '0;
        hwdata        = '0;
        gaps_on       = 1'b0;
        burst_count   = 0;
        wb_count      = 0;
        last_wb_line  = '0;
        error_count   = 0;
        timeout_count = 0;
        for (int s = 0; s < N_SRC; s++) begin
            htrans[s] = IDLE;
            hsize[s]  = WORD;
        end
        for (int i = 0; i < MEM_BEATS; i++) begin
            mem[i] = pattern_beat(i);
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RESET_IN = 1'b0;

        after_reset_state();
        if (timeout_count == 0) read_miss_then_hit();
        if (timeout_count == 0) write_then_evict();
        if (timeout_count == 0) concurrent_ports();
        if (timeout_count == 0) random_traffic();
        if (timeout_count == 0) flush_and_compare();

        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/cache_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_subsystem
    import cache_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET_IN,

    // AHB-Lite masters
    input  addr_t  [N_SRC-1:0]   haddr,
    input  trans_t [N_SRC-1:0]   htrans,
    input  size_t  [N_SRC-1:0]   hsize,
    input  logic   [N_SRC-1:0]   hwrite,
    input  data_t  [N_SRC-1:0]   hwdata,
    output data_t  [N_SRC-1:0]   hrdata,
    output logic   [N_SRC-1:0]   hready,
    output resp_t  [N_SRC-1:0]   hresp,

    // External SDRAM
    output logic                 dram_req,
    output logic                 dram_write,
    output line_addr_t           dram_addr,
    output beat_t                dram_wdata,
    input  logic                 dram_ack,
    input  beat_t                dram_rdata
);

    logic       [N_LINES-1:0] fill_req;
    logic       [N_LINES-1:0] wb_req;
    line_addr_t [N_LINES-1:0] line_addr;
    logic       [N_LINES-1:0] grant;
    beat_idx_t                beat_idx;
    logic                     beat_strobe;
    beat_t                    fill_beat;
    logic                     burst_done;
    beat_t                    wb_beat;

    sdram_cache u_cache (
        .CLK        (CLK),
        .RESET_IN   (RESET_IN),
        .haddr      (haddr),
        .htrans     (htrans),
        .hsize      (hsize),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hrdata     (hrdata),
        .hready     (hready),
        .hresp      (hresp),
        .fill_req   (fill_req),
        .wb_req     (wb_req),
        .line_addr  (line_addr),
        .grant      (grant),
        .beat_idx   (beat_idx),
        .beat_strobe(beat_strobe),
        .fill_beat  (fill_beat),
        .burst_done (burst_done),
        .wb_beat    (wb_beat)
    );

    dram_sequencer u_seq (
        .CLK        (CLK),
        .RESET_IN   (RESET_IN),
        .fill_req   (fill_req),
        .wb_req     (wb_req),
        .line_addr  (line_addr),
        .grant      (grant),
        .beat_idx   (beat_idx),
        .beat_strobe(beat_strobe),
        .fill_beat  (fill_beat),
        .burst_done (burst_done),
        .wb_beat    (wb_beat),
        .dram_req   (dram_req),
        .dram_write (dram_write),
        .dram_addr  (dram_addr),
        .dram_wdata (dram_wdata),
        .dram_ack   (dram_ack),
        .dram_rdata (dram_rdata)
    );

endmodule

`default_nettype wire

// ==== design/dram_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module dram_sequencer
    import cache_pkg::*;
(
    input  logic                     CLK,
    input  logic                     RESET_IN,

    // Line side
    input  logic       [N_LINES-1:0] fill_req,
    input  logic       [N_LINES-1:0] wb_req,
    input  line_addr_t [N_LINES-1:0] line_addr,
    output logic       [N_LINES-1:0] grant,
    output beat_idx_t                beat_idx,
    output logic                     beat_strobe,
    output beat_t                    fill_beat,
    output logic                     burst_done,
    input  beat_t                    wb_beat,

    // SDRAM burst port
    output logic                     dram_req,
    output logic                     dram_write,
    output line_addr_t               dram_addr,
    output beat_t                    dram_wdata,
    input  logic                     dram_ack,
    input  beat_t                    dram_rdata
);

    seq_state_t         state;
    logic [N_LINES-1:0] pick;
    logic               pick_wb;
    line_addr_t         pick_addr;

    // Lowest requesting line, writeback before fill
    always_comb begin
        pick      = '0;
        pick_wb   = 1'b0;
        pick_addr = '0;
        for (int l = N_LINES - 1; l >= 0; l--) begin
            if (fill_req[l] || wb_req[l]) begin
                pick      = {{(N_LINES-1){1'b0}}, 1'b1} << l;
                pick_wb   = wb_req[l];
                pick_addr = line_addr[l];
            end
        end
    end

    assign beat_strobe = dram_ack && state == S_BURST;
    assign burst_done  = beat_strobe && beat_idx == beat_idx_t'(BURST - 1);
    assign fill_beat   = dram_rdata;
    assign dram_wdata  = wb_beat;

    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            state    <= S_IDLE;
            grant    <= '0;
            dram_req <= 1'b0;
            beat_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (|pick) begin
                        state    <= S_BURST;
                        grant    <= pick;
                        dram_req <= 1'b1;
                        beat_idx <= '0;
                    end
                end
                S_BURST: begin
                    if (beat_strobe) begin
                        beat_idx <= beat_idx + 1'b1;
                    end
                    if (burst_done) begin
                        state    <= S_IDLE;
                        grant    <= '0;
                        dram_req <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Address and direction are latched with the grant
    always_ff @(posedge CLK) begin
        if (state == S_IDLE && |pick) begin
            dram_addr  <= pick_addr;
            dram_write <= pick_wb;
        end
    end

    a_grant_onehot: assert property (@(posedge CLK) disable iff (RESET_IN)
        $onehot0(grant));

    a_req_stable: assert property (@(posedge CLK) disable iff (RESET_IN)
        $past(dram_req) && dram_req |-> $stable(dram_addr) && $stable(dram_write));

endmodule

`default_nettype wire

// ==== design/sdram_cache/sdram_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

module sdram_cache
    import cache_pkg::*;
(
    input  logic                     CLK,
    input  logic                     RESET_IN,

    // AHB-Lite ports
    input  addr_t      [N_SRC-1:0]   haddr,
    input  trans_t     [N_SRC-1:0]   htrans,
    input  size_t      [N_SRC-1:0]   hsize,
    input  logic       [N_SRC-1:0]   hwrite,
    input  data_t      [N_SRC-1:0]   hwdata,
    output data_t      [N_SRC-1:0]   hrdata,
    output logic       [N_SRC-1:0]   hready,
    output resp_t      [N_SRC-1:0]   hresp,

    // Line requests to the sequencer
    output logic       [N_LINES-1:0] fill_req,
    output logic       [N_LINES-1:0] wb_req,
    output line_addr_t [N_LINES-1:0] line_addr,

    // Burst progress from the sequencer
    input  logic       [N_LINES-1:0] grant,
    input  beat_idx_t                beat_idx,
    input  logic                     beat_strobe,
    input  beat_t                    fill_beat,
    input  logic                     burst_done,
    output beat_t                    wb_beat
);

    // Per source
    addr_t     [N_SRC-1:0] acc_addr;
    logic      [N_SRC-1:0] acc_write;
    logic      [N_SRC-1:0] access_pend;
    logic      [N_SRC-1:0] hit;
    data_t     [N_SRC-1:0] line_word;
    index_t    [N_SRC-1:0] src_index;
    tag_t      [N_SRC-1:0] src_tag;
    word_sel_t [N_SRC-1:0] src_word;

    // Per line state
    line_t     [N_LINES-1:0] data_q;
    tag_t      [N_LINES-1:0] tag_q;
    tag_t      [N_LINES-1:0] pend_tag;
    logic      [N_LINES-1:0] valid;
    logic      [N_LINES-1:0] dirty;
    logic      [N_LINES-1:0] pending;

    // Per line decisions
    logic      [N_LINES-1:0] sel_any;
    src_idx_t  [N_LINES-1:0] sel_src;
    logic      [N_LINES-1:0] tag_match;
    logic      [N_LINES-1:0] line_hit;
    logic      [N_LINES-1:0] wr_hit;
    logic      [N_LINES-1:0] start_fill;

    for (genvar s = 0; s < N_SRC; s++) begin : gen_port
        ahb_port u_port (
            .CLK        (CLK),
            .RESET_IN   (RESET_IN),
            .haddr      (haddr[s]),
            .htrans     (htrans[s]),
            .hsize      (hsize[s]),
            .hwrite     (hwrite[s]),
            .hwdata     (hwdata[s]),
            .hrdata     (hrdata[s]),
            .hready     (hready[s]),
            .hresp      (hresp[s]),
            .acc_addr   (acc_addr[s]),
            .acc_write  (acc_write[s]),
            .access_pend(access_pend[s]),
            .hit        (hit[s]),
            .line_word  (line_word[s])
        );
    end

    always_comb begin
        for (int s = 0; s < N_SRC; s++) begin
            src_index[s] = acc_addr[s][OFS_BITS +: INDEX_BITS];
            src_tag[s]   = acc_addr[s][OFS_BITS+INDEX_BITS +: TAG_BITS];
            src_word[s]  = acc_addr[s][BYTE_SEL_BITS +: WORD_SEL_BITS];
        end
    end

    // Lowest-numbered pending source wins each line
    always_comb begin
        for (int l = 0; l < N_LINES; l++) begin
            sel_any[l] = 1'b0;
            sel_src[l] = '0;
            for (int s = N_SRC - 1; s >= 0; s--) begin
                if (access_pend[s] && src_index[s] == index_t'(l)) begin
                    sel_any[l] = 1'b1;
                    sel_src[l] = src_idx_t'(s);
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < N_LINES; l++) begin
            tag_match[l]  = valid[l] && tag_q[l] == src_tag[sel_src[l]];
            // No hits while a burst owns the line
            line_hit[l]   = sel_any[l] && tag_match[l] && !grant[l];
            wr_hit[l]     = line_hit[l] && acc_write[sel_src[l]];
            start_fill[l] = sel_any[l] && !tag_match[l] && !dirty[l] && !pending[l];
            wb_req[l]     = sel_any[l] && !tag_match[l] && dirty[l];
            fill_req[l]   = pending[l];
            line_addr[l]  = {pending[l] ? pend_tag[l] : tag_q[l], index_t'(l)};
        end
    end

    always_comb begin
        for (int s = 0; s < N_SRC; s++) begin
            hit[s] = access_pend[s] && line_hit[src_index[s]]
                     && sel_src[src_index[s]] == src_idx_t'(s);
            line_word[s] = data_q[src_index[s]][DATA_BITS*src_word[s] +: DATA_BITS];
        end
    end

    // Beat of the line being written back
    always_comb begin
        wb_beat = '0;
        for (int l = 0; l < N_LINES; l++) begin
            if (grant[l]) begin
                wb_beat = data_q[l][BEAT_BITS*beat_idx +: BEAT_BITS];
            end
        end
    end

    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            valid   <= '0;
            dirty   <= '0;
            pending <= '0;
        end else begin
            for (int l = 0; l < N_LINES; l++) begin
                if (start_fill[l]) begin
                    pending[l] <= 1'b1;
                    valid[l]   <= 1'b0;
                end else if (pending[l] && grant[l] && burst_done) begin
                    pending[l] <= 1'b0;
                    valid[l]   <= 1'b1;
                end
                // Writeback finished, line is clean again
                if (wr_hit[l]) begin
                    dirty[l] <= 1'b1;
                end else if (!pending[l] && grant[l] && burst_done) begin
                    dirty[l] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int l = 0; l < N_LINES; l++) begin
            if (start_fill[l]) begin
                pend_tag[l] <= src_tag[sel_src[l]];
            end
            if (pending[l] && grant[l] && burst_done) begin
                tag_q[l] <= pend_tag[l];
            end
            if (pending[l] && grant[l] && beat_strobe) begin
                data_q[l][BEAT_BITS*beat_idx +: BEAT_BITS] <= fill_beat;
            end else if (wr_hit[l]) begin
                data_q[l][DATA_BITS*src_word[sel_src[l]] +: DATA_BITS] <= hwdata[sel_src[l]];
            end
        end
    end

    // Every burst beat belongs to a line that is filling or writing back
    a_beat_owned: assert property (@(posedge CLK) disable iff (RESET_IN)
        beat_strobe |-> |(grant & (pending | dirty)));

endmodule

`default_nettype wire

// ==== design/sdram_cache/ahb_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module ahb_port
    import cache_pkg::*;
(
    input  logic   CLK,
    input  logic   RESET_IN,

    // AHB-Lite slave side
    input  addr_t  haddr,
    input  trans_t htrans,
    input  size_t  hsize,
    input  logic   hwrite,
    input  data_t  hwdata,
    output data_t  hrdata,
    output logic   hready,
    output resp_t  hresp,

    // Towards the line arrays
    output addr_t  acc_addr,
    output logic   acc_write,
    output logic   access_pend,
    input  logic   hit,
    input  data_t  line_word
);

    logic addr_phase;
    logic done;

    assign addr_phase = hready && (htrans == NONSEQ || htrans == SEQ);
    assign done       = access_pend && hit;

    // Data phase stalls for as long as an access is outstanding
    assign hready = !access_pend;
    assign hresp  = OKAY;

    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            access_pend <= 1'b0;
        end else if (addr_phase) begin
            access_pend <= 1'b1;
        end else if (done) begin
            access_pend <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (addr_phase) begin
            acc_addr  <= haddr;
            acc_write <= hwrite;
        end
        // Writes echo the stored word back on the read bus
        if (done) begin
            hrdata <= acc_write ? hwdata : line_word;
        end
    end

    // Only word transfers are handled by the line arrays
    a_word_only: assert property (@(posedge CLK) disable iff (RESET_IN)
        addr_phase |-> hsize == WORD);

endmodule

`default_nettype wire

// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // Ports and cache geometry
    localparam int N_SRC     = 4;
    localparam int N_LINES   = 8;
    localparam int BURST     = 8;
    localparam int MAX_BYTES = 65536;

    // Bus widths
    localparam int ADDR_BITS = $clog2(MAX_BYTES);
    localparam int DATA_BITS = 32;
    localparam int BEAT_BITS = 16;

    // Address split into tag, index and byte offset
    localparam int LINE_BYTES     = BURST * BEAT_BITS / 8;
    localparam int OFS_BITS       = $clog2(LINE_BYTES);
    localparam int INDEX_BITS     = $clog2(N_LINES);
    localparam int TAG_BITS       = ADDR_BITS - OFS_BITS - INDEX_BITS;
    localparam int BEAT_IDX_BITS  = $clog2(BURST);
    localparam int BYTE_SEL_BITS  = $clog2(DATA_BITS / 8);
    localparam int WORD_SEL_BITS  = OFS_BITS - BYTE_SEL_BITS;
    localparam int SRC_BITS       = $clog2(N_SRC);

    typedef logic [ADDR_BITS-1:0]           addr_t;
    typedef logic [DATA_BITS-1:0]           data_t;
    typedef logic [BEAT_BITS-1:0]           beat_t;
    typedef logic [LINE_BYTES*8-1:0]        line_t;
    typedef logic [OFS_BITS-1:0]            ofs_t;
    typedef logic [INDEX_BITS-1:0]          index_t;
    typedef logic [TAG_BITS-1:0]            tag_t;
    typedef logic [BEAT_IDX_BITS-1:0]       beat_idx_t;
    typedef logic [TAG_BITS+INDEX_BITS-1:0] line_addr_t;
    typedef logic [WORD_SEL_BITS-1:0]       word_sel_t;
    typedef logic [SRC_BITS-1:0]            src_idx_t;

    // AHB encodings
    typedef enum logic [1:0] {IDLE = 2'd0, BUSY = 2'd1, NONSEQ = 2'd2, SEQ = 2'd3} trans_t;
    typedef enum logic [2:0] {BYTE = 3'd0, HALF = 3'd1, WORD = 3'd2} size_t;
    typedef enum logic {OKAY = 1'b0, ERROR = 1'b1} resp_t;

    // SDRAM sequencer states
    typedef enum logic {S_IDLE, S_BURST} seq_state_t;

endpackage

`default_nettype wire
